/* verilog/mul_pkg.sv */
//##################################################
// Multiplier package
// Operand, tile and product widths
// Request, tile and product struct types
//##################################################

package mul_pkg;

	// Operand and tile geometry
	localparam int OP_WIDTH   = 32;
	localparam int TILE_WIDTH = 8;
	localparam int SLICES     = OP_WIDTH / TILE_WIDTH;
	localparam int NUM_TILES  = SLICES * SLICES;
	localparam int PROD_WIDTH = 2 * OP_WIDTH;

	typedef logic [OP_WIDTH-1:0]     operand_t;
	typedef logic [PROD_WIDTH-1:0]   product_t;
	typedef logic [TILE_WIDTH-1:0]   tile_byte_t;
	typedef logic [2*TILE_WIDTH-1:0] tile_prod_t;

	// Operand pair as presented by the requester
	typedef struct packed {
		operand_t a;
		operand_t b;
	} mul_req_t;

	// Byte pair for one 8x8 tile
	typedef struct packed {
		tile_byte_t a;
		tile_byte_t b;
	} tile_in_t;

	// Index k holds a slice k / SLICES and b slice k % SLICES
	typedef tile_in_t   [NUM_TILES-1:0] tile_in_vec_t;
	typedef tile_prod_t [NUM_TILES-1:0] tile_prod_vec_t;

endpackage

/* verilog/req_ack_ctrl.sv */
//##################################################
// Four-phase req/ack handshake FSM
// Operand and product load strobes
//##################################################

`timescale 1ns/1ns

module req_ack_ctrl import mul_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	input  logic req,
	output logic ack,
	output logic load_operands,
	output logic load_product
);

	typedef enum logic [1:0] {
		IDLE = 2'd0,
		BUSY = 2'd1,
		DONE = 2'd2
	} state_t;

	state_t state;
	state_t state_next;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (req) begin
					state_next = BUSY;
				end
			end
			// Tiles and sum settle during this cycle
			BUSY: begin
				state_next = DONE;
			end
			// Hold until the requester lets go of req
			DONE: begin
				if (!req) begin
					state_next = IDLE;
				end
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	// Operands captured on the edge that accepts req
	assign load_operands = (state == IDLE) && req;

	// Product captured one edge later
	assign load_product = (state == BUSY);

	assign ack = (state == DONE);

endmodule

/* verilog/operand_slicer.sv */
//##################################################
// Operand register
// Byte pair fan-out to the tile array
//##################################################

`timescale 1ns/1ns

module operand_slicer import mul_pkg::*; (
	input  logic         clk,
	input  logic         arst_n,
	input  logic         load_operands,
	input  mul_req_t     operands,
	output tile_in_vec_t tiles
);

	mul_req_t op_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op_q <= '0;
		end else if (load_operands) begin
			op_q <= operands;
		end
	end

	// Tile k gets a byte k / SLICES and b byte k % SLICES
	always_comb begin
		int i;
		int j;
		for (int k = 0; k < NUM_TILES; k++) begin
			i = k / SLICES;
			j = k % SLICES;
			tiles[k].a = op_q.a[TILE_WIDTH*i +: TILE_WIDTH];
			tiles[k].b = op_q.b[TILE_WIDTH*j +: TILE_WIDTH];
		end
	end

endmodule

/* verilog/wallace_tile8.sv */
//##################################################
// 8x8 Wallace tree tile
// Carry-save reduction, 8 -> 6 -> 4 -> 3 -> 2 rows
// Final ripple add into the 16-bit product
//##################################################

`timescale 1ns/1ns

module wallace_tile8 import mul_pkg::*; (
	input  tile_in_t   tile,
	output tile_prod_t prod
);

	localparam int ROW_W = 2 * TILE_WIDTH;

	typedef struct packed {
		tile_prod_t sum;
		tile_prod_t carry;
	} csa_t;

	// One row of full adders, carries moved up one column
	function automatic csa_t csa(
		input tile_prod_t x,
		input tile_prod_t y,
		input tile_prod_t z
	);
		csa_t r;
		r.sum   = x ^ y ^ z;
		r.carry = ((x & y) | (x & z) | (y & z)) << 1;
		return r;
	endfunction

	tile_prod_t pp [TILE_WIDTH];

	csa_t lvl1_a;
	csa_t lvl1_b;
	csa_t lvl2_a;
	csa_t lvl2_b;
	csa_t lvl3;
	csa_t lvl4;

	// Partial product rows, row i shifted by i
	always_comb begin
		for (int i = 0; i < TILE_WIDTH; i++) begin
			pp[i] = tile_prod_t'(tile.a & {TILE_WIDTH{tile.b[i]}}) << i;
		end
	end

	// Level 1, 8 rows to 6
	assign lvl1_a = csa(pp[0], pp[1], pp[2]);
	assign lvl1_b = csa(pp[3], pp[4], pp[5]);

	// Level 2, 6 rows to 4
	assign lvl2_a = csa(lvl1_a.sum, lvl1_a.carry, lvl1_b.sum);
	assign lvl2_b = csa(lvl1_b.carry, pp[6], pp[7]);

	// Level 3, 4 rows to 3
	assign lvl3 = csa(lvl2_a.sum, lvl2_a.carry, lvl2_b.sum);

	// Level 4, 3 rows to 2
	assign lvl4 = csa(lvl3.sum, lvl3.carry, lvl2_b.carry);

	// Last two rows through a plain ripple adder
	always_comb begin
		logic c;
		logic x;
		logic y;
		c = 1'b0;
		for (int i = 0; i < ROW_W; i++) begin
			x       = lvl4.sum[i];
			y       = lvl4.carry[i];
			prod[i] = x ^ y ^ c;
			c       = (x & y) | (c & (x ^ y));
		end
	end

endmodule

/* verilog/product_accumulator.sv */
//##################################################
// Weighted sum of the tile products
// 64-bit product register
//##################################################

`timescale 1ns/1ns

module product_accumulator import mul_pkg::*; (
	input  logic           clk,
	input  logic           arst_n,
	input  logic           load_product,
	input  tile_prod_vec_t tile_prods,
	output product_t       product
);

	product_t sum;

	// Tile k sits at 8 * (k / SLICES + k % SLICES)
	always_comb begin
		int shift;
		sum = '0;
		for (int k = 0; k < NUM_TILES; k++) begin
			shift = TILE_WIDTH * (k / SLICES + k % SLICES);
			sum   = sum + (product_t'(tile_prods[k]) << shift);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			product <= '0;
		end else if (load_product) begin
			product <= sum;
		end
	end

endmodule

/* verilog/mul_top.sv */
//##################################################
// 32x32 multiplier top level
// Handshake FSM, slicer, 16 tiles, accumulator
//##################################################

`timescale 1ns/1ns

module mul_top import mul_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     req,
	input  mul_req_t operands,
	output logic     ack,
	output product_t product
);

	logic           load_operands;
	logic           load_product;
	tile_in_vec_t   tiles;
	tile_prod_vec_t tile_prods;

	req_ack_ctrl u_ctrl (
		.clk           (clk),
		.arst_n        (arst_n),
		.req           (req),
		.ack           (ack),
		.load_operands (load_operands),
		.load_product  (load_product)
	);

	operand_slicer u_slicer (
		.clk           (clk),
		.arst_n        (arst_n),
		.load_operands (load_operands),
		.operands      (operands),
		.tiles         (tiles)
	);

	// One tile per byte pair
	for (genvar k = 0; k < NUM_TILES; k++) begin : g_tile
		wallace_tile8 u_tile (
			.tile (tiles[k]),
			.prod (tile_prods[k])
		);
	end

	product_accumulator u_acc (
		.clk          (clk),
		.arst_n       (arst_n),
		.load_product (load_product),
		.tile_prods   (tile_prods),
		.product      (product)
	);

endmodule

/* test/mul_assert.sv */
//##################################################
// Handshake assertions, bound into mul_top
//##################################################

`timescale 1ns/1ns

module mul_assert import mul_pkg::*; (
	input logic     clk,
	input logic     arst_n,
	input logic     req,
	input logic     ack,
	input product_t product
);

	int unsigned fail_count = 0;

	ack_low_in_reset: assert property (@(posedge clk) !arst_n |-> !ack)
		else begin
			fail_count++;
			$error("ack high during reset");
		end

	// req is already low when ack is first seen high on a short handshake
	ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(ack) |-> $past(req))
		else begin
			fail_count++;
			$error("ack rose without req");
		end

	product_stable: assert property (@(posedge clk) disable iff (!arst_n)
		ack && $past(ack) |-> $stable(product))
		else begin
			fail_count++;
			$error("product changed while ack high");
		end

	ack_falls: assert property (@(posedge clk) disable iff (!arst_n)
		ack && !req |=> !ack)
		else begin
			fail_count++;
			$error("ack did not fall after req low");
		end

endmodule

bind mul_top mul_assert u_assert (.*);

/* test/mul_tb.sv */
//##################################################
// Testbench for the 32x32 multiplier
// Clock, reset, LFSR, directed tests, checks
//##################################################

`timescale 1ns/1ns

module mul_tb import mul_pkg::*; ();

	localparam logic [31:0] LFSR_SEED = 32'ha3e6_8c91;
	// About 270 transactions of at most 6 cycles, with margin
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int NUM_RANDOM     = 200;

	logic     clk;
	logic     arst_n;
	logic     req;
	mul_req_t operands;
	logic     ack;
	product_t product;

	logic [31:0] lfsr_state = LFSR_SEED;
	int          cycles     = 0;

	mul_top uut (
		.clk      (clk),
		.arst_n   (arst_n),
		.req      (req),
		.operands (operands),
		.ack      (ack),
		.product  (product)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display("ERRORS FOUND");
			$fatal(1, "Simulation stopped by the cycle limit");
		end
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic fb;
		fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic operand_t random_operand();
		operand_t v;
		for (int n = 0; n < OP_WIDTH; n++) begin
			v[n] = lfsr_bit();
		end
		return v;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("FAIL at %0t ns: %s", $time, msg);
		$display("ERRORS FOUND");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_product(input product_t got, input product_t exp, input string what);
		if (got !== exp) begin
			stop_on_error($sformatf("%s: product %h, expected %h", what, got, exp));
		end
	endtask

	task automatic check_ack(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			stop_on_error($sformatf("%s: ack %b, expected %b", what, got, exp));
		end
	endtask

	// Inputs change 5 ns after the rising edge, outputs are settled there
	task automatic wait_drive_slot();
		@(posedge clk);
		#5;
	endtask

	// One four-phase handshake, hold is extra cycles with req kept high
	task automatic run_transaction(input operand_t a, input operand_t b,
			input product_t expected, input int hold);
		operands.a = a;
		operands.b = b;
		req        = 1'b1;
		wait_drive_slot();
		check_ack(ack, 1'b0, "ack before product load");
		wait_drive_slot();
		check_ack(ack, 1'b1, "ack two edges after req");
		check_product(product, expected, $sformatf("%h * %h", a, b));
		repeat (hold) begin
			wait_drive_slot();
			check_ack(ack, 1'b1, "ack held while req high");
			check_product(product, expected, "product held while req high");
		end
		req = 1'b0;
		wait_drive_slot();
		check_ack(ack, 1'b0, "ack one edge after req dropped");
		check_product(product, expected, "product after ack fell");
	endtask

	task automatic test_reset_values();
		check_ack(ack, 1'b0, "ack after reset");
		check_product(product, '0, "product after reset");
	endtask

	// Zero products follow nonzero ones so a missed load shows up
	task automatic test_identities();
		operand_t r;
		r = random_operand();
		run_transaction(operand_t'(1), r, product_t'(r), 0);
		run_transaction('0, r, '0, 0);
		r = random_operand();
		run_transaction(r, operand_t'(1), product_t'(r), 0);
		run_transaction(r, '0, '0, 0);
		run_transaction('1, '1, 64'hffff_fffe_0000_0001, 0);
	endtask

	// Single bit at p + q, every tile weight gets hit
	task automatic test_walking_ones();
		int q;
		for (int p = 0; p < OP_WIDTH; p++) begin
			q = (p * 5 + 3) % OP_WIDTH;
			run_transaction(operand_t'(1) << p, operand_t'(1) << q,
				product_t'(1) << (p + q), 0);
		end
		for (int p = 0; p < OP_WIDTH; p++) begin
			q = (p * 7 + 1) % OP_WIDTH;
			run_transaction(operand_t'(1) << q, operand_t'(1) << p,
				product_t'(1) << (p + q), 0);
		end
	endtask

	task automatic test_random();
		operand_t a;
		operand_t b;
		for (int n = 0; n < NUM_RANDOM; n++) begin
			a = random_operand();
			b = random_operand();
			run_transaction(a, b, product_t'(a) * product_t'(b), 0);
		end
	endtask

	// Long hold, then a second request right after ack falls
	task automatic test_handshake();
		operand_t a;
		operand_t b;
		a = random_operand();
		b = random_operand();
		run_transaction(a, b, product_t'(a) * product_t'(b), 10);
		a = random_operand();
		b = random_operand();
		run_transaction(a, b, product_t'(a) * product_t'(b), 0);
	endtask

	initial begin
		arst_n   = 1'b0;
		req      = 1'b0;
		operands = '0;
		repeat (2) @(posedge clk);
		#5;
		arst_n = 1'b1;
		test_reset_values();
		test_identities();
		test_walking_ones();
		test_random();
		test_handshake();
		if (uut.u_assert.fail_count != 0) begin
			$display("%0d handshake assertions failed", uut.u_assert.fail_count);
			$display("ERRORS FOUND");
			$fatal(1, "Stopped on assertion failures");
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

/* src.f */
verilog/mul_pkg.sv
verilog/req_ack_ctrl.sv
verilog/operand_slicer.sv
verilog/wallace_tile8.sv
verilog/product_accumulator.sv
verilog/mul_top.sv
test/mul_assert.sv
test/mul_tb.sv

/* Makefile */
# Verilator build and run for the 32x32 multiplier

VERILATOR ?= verilator
TOP       ?= mul_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timing -j 0

SOURCES := $(shell cat $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulator is the pass or fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
